/* verilog/id_pkg.sv */
// RV32I base encodings only, so compressed, CSR and M opcodes decode as illegal in this stage
package id_pkg;

  //////////////////////////////////////////////////
  // Widths and instruction field positions
  //////////////////////////////////////////////////

  localparam int unsigned XLEN           = 32;
  localparam int unsigned REG_ADDR_W     = 5;
  localparam int unsigned NUM_READ_PORTS = 2;

  localparam int unsigned OPCODE_W   = 7;
  localparam int unsigned FUNCT3_W   = 3;
  localparam int unsigned RD_LSB     = 7;
  localparam int unsigned FUNCT3_LSB = 12;
  localparam int unsigned RS1_LSB    = 15;
  localparam int unsigned RS2_LSB    = 20;
  localparam int unsigned FUNCT7_LSB = 25;

  // Major opcodes
  localparam logic [OPCODE_W-1:0] OPC_OP     = 7'b0110011;
  localparam logic [OPCODE_W-1:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [OPCODE_W-1:0] OPC_LUI    = 7'b0110111;
  localparam logic [OPCODE_W-1:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [OPCODE_W-1:0] OPC_JAL    = 7'b1101111;
  localparam logic [OPCODE_W-1:0] OPC_JALR   = 7'b1100111;
  localparam logic [OPCODE_W-1:0] OPC_BRANCH = 7'b1100011;
  localparam logic [OPCODE_W-1:0] OPC_LOAD   = 7'b0000011;
  localparam logic [OPCODE_W-1:0] OPC_STORE  = 7'b0100011;

  //////////////////////////////////////////////////
  // Basic types and mux selects
  //////////////////////////////////////////////////

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [XLEN-1:0]       word_t;

  // Arithmetic ops first, branch compares after
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR,  ALU_AND, ALU_EQ,  ALU_NE,  ALU_LT,   ALU_GE,  ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_REG, OP_B_IMM, OP_B_PCINCR} op_b_sel_e;
  typedef enum logic       {OP_C_REGB, OP_C_BCH} op_c_sel_e;

  //////////////////////////////////////////////////
  // Stage structs
  //////////////////////////////////////////////////

  // From fetch
  typedef struct packed {
    logic  instr_valid;
    word_t pc;
    word_t instr;
  } if_id_t;

  // Write port of a later stage, used as forwarding source
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
  } wr_port_t;

  // Decoder result
  typedef struct packed {
    logic      alu_en;
    logic      alu_bch;
    logic      alu_jmp;
    logic      alu_jmpr;
    logic      lsu_en;
    logic      lsu_we;
    logic      lsu_sext;
    logic      rf_we;
    alu_op_e   alu_op;
    logic [1:0] lsu_size;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    op_c_sel_e op_c_sel;
    logic      illegal;
    word_t     imm_b;
    word_t     imm_sb;
  } dec_ctrl_t;

  // ID/EX pipeline register
  typedef struct packed {
    logic       valid;
    word_t      pc;
    word_t      pc_next;
    word_t      operand_a;
    word_t      operand_b;
    word_t      operand_c;
    logic       alu_en;
    logic       alu_bch;
    logic       alu_jmp;
    alu_op_e    alu_op;
    logic       lsu_en;
    logic       lsu_we;
    logic [1:0] lsu_size;
    logic       lsu_sext;
    logic       rf_we;
    reg_addr_t  rf_waddr;
    logic       illegal;
  } id_ex_t;

endpackage

/* verilog/id_decoder.sv */
// Purely combinational; loads and stores leave alu_en clear, since EX forms the address in the LSU
`timescale 1ns/1ps

module id_decoder import id_pkg::*; (
  input  word_t     instr_i,
  output dec_ctrl_t ctrl_o
);

  logic [OPCODE_W-1:0] opcode;
  logic [FUNCT3_W-1:0] funct3;
  logic [6:0]          funct7;
  word_t               imm_i;
  word_t               imm_s;
  word_t               imm_sb;
  word_t               imm_u;
  word_t               imm_uj;
  alu_op_e             arith_op;
  logic                illegal;

  assign opcode = instr_i[OPCODE_W-1:0];
  assign funct3 = instr_i[FUNCT3_LSB +: FUNCT3_W];
  assign funct7 = instr_i[FUNCT7_LSB +: 7];

  // Sign extended immediates
  assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_sb = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u  = {instr_i[31:12], 12'b0};
  assign imm_uj = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  // Shared funct3 map of OP and OP-IMM
  // funct7 bit 5 picks SRA here, SUB is handled for OP only
  always_comb begin
    case (funct3)
      3'b000:  arith_op = ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    ctrl_o          = '0;
    ctrl_o.alu_op   = ALU_ADD;
    ctrl_o.op_a_sel = OP_A_REG;
    ctrl_o.op_b_sel = OP_B_REG;
    ctrl_o.op_c_sel = OP_C_REGB;
    ctrl_o.imm_b    = imm_i;
    ctrl_o.imm_sb   = imm_sb;
    illegal         = 1'b0;

    case (opcode)
      OPC_OP: begin
        ctrl_o.alu_en = 1'b1;
        ctrl_o.rf_we  = 1'b1;
        ctrl_o.alu_op = (funct3 == 3'b000 && funct7[5]) ? ALU_SUB : arith_op;
        // Only ADD/SUB and SRL/SRA accept the alternate funct7
        illegal = !((funct7 == 7'b0000000) ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      OPC_OPIMM: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.alu_op   = arith_op;
        ctrl_o.op_b_sel = OP_B_IMM;
        // Shift immediates reuse the funct7 slot
        if (funct3 == 3'b001) begin
          illegal = (funct7 != 7'b0000000);
        end else if (funct3 == 3'b101) begin
          illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
        end
      end
      OPC_LUI, OPC_AUIPC: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = (opcode == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.imm_b    = imm_u;
      end
      OPC_JAL, OPC_JALR: begin
        // Link address pc + 4 is computed in the ALU
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.alu_jmp  = 1'b1;
        ctrl_o.alu_jmpr = (opcode == OPC_JALR);
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = OP_A_PC;
        ctrl_o.op_b_sel = OP_B_PCINCR;
        ctrl_o.imm_b    = (opcode == OPC_JAL) ? imm_uj : imm_i;
        illegal         = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.alu_bch  = 1'b1;
        ctrl_o.op_c_sel = OP_C_BCH;
        case (funct3)
          3'b000:  ctrl_o.alu_op = ALU_EQ;
          3'b001:  ctrl_o.alu_op = ALU_NE;
          3'b100:  ctrl_o.alu_op = ALU_LT;
          3'b101:  ctrl_o.alu_op = ALU_GE;
          3'b110:  ctrl_o.alu_op = ALU_LTU;
          3'b111:  ctrl_o.alu_op = ALU_GEU;
          default: illegal       = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        ctrl_o.lsu_en   = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.lsu_size = funct3[1:0];
        ctrl_o.lsu_sext = !funct3[2];
        ctrl_o.op_b_sel = OP_B_IMM;
        // LB LH LW LBU LHU
        illegal = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      OPC_STORE: begin
        ctrl_o.lsu_en   = 1'b1;
        ctrl_o.lsu_we   = 1'b1;
        ctrl_o.lsu_size = funct3[1:0];
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.imm_b    = imm_s;
        illegal         = funct3[2] || (funct3[1:0] == 2'b11);
      end
      default: illegal = 1'b1;
    endcase

    // Unknown encodings must not start any unit or write the register file
    if (illegal) begin
      ctrl_o.alu_en   = 1'b0;
      ctrl_o.alu_bch  = 1'b0;
      ctrl_o.alu_jmp  = 1'b0;
      ctrl_o.alu_jmpr = 1'b0;
      ctrl_o.lsu_en   = 1'b0;
      ctrl_o.lsu_we   = 1'b0;
      ctrl_o.lsu_sext = 1'b0;
      ctrl_o.rf_we    = 1'b0;
    end
    ctrl_o.illegal = illegal;
  end

  // No write-back may leave ID for a flagged instruction
  always_comb begin
    assert (!(ctrl_o.illegal && ctrl_o.rf_we))
      else $error("illegal instruction with rf_we set");
  end

endmodule

/* verilog/id_operand_fwd.sv */
// One read port; EX and WB write ports are compared here, register x0 always reads the file
`timescale 1ns/1ps

module id_operand_fwd import id_pkg::*; (
  input  reg_addr_t raddr_i,
  input  word_t     rf_rdata_i,
  input  wr_port_t  ex_wr_i,
  input  wr_port_t  wb_wr_i,
  output word_t     operand_o
);

  logic raddr_nz;
  logic ex_hit;
  logic wb_hit;

  // x0 is hardwired, never forward it
  assign raddr_nz = |raddr_i;

  assign ex_hit = raddr_nz && ex_wr_i.we && (ex_wr_i.waddr == raddr_i);
  assign wb_hit = raddr_nz && wb_wr_i.we && (wb_wr_i.waddr == raddr_i);

  // Youngest producer first
  always_comb begin
    if (ex_hit) begin
      operand_o = ex_wr_i.wdata;
    end else if (wb_hit) begin
      operand_o = wb_wr_i.wdata;
    end else begin
      operand_o = rf_rdata_i;
    end
  end

  // A read of x0 sees the file data whatever the later stages write
  always_comb begin
    if (!raddr_nz) begin
      assert (operand_o == rf_rdata_i)
        else $error("x0 read returned forwarded data");
    end
  end

endmodule

/* verilog/id_target.sv */
// Targets assume 4-byte instructions; jmp_target_o is only meaningful while alu_jmp is set
`timescale 1ns/1ps

module id_target import id_pkg::*; (
  input  word_t     pc_i,
  input  dec_ctrl_t ctrl_i,
  input  word_t     rs1_i,
  output word_t     bch_target_o,
  output word_t     jmp_target_o,
  output word_t     pc_next_o
);

  word_t jmp_base;
  word_t jmp_sum;

  //////////////////////////////////////////////////
  // Branch target
  //////////////////////////////////////////////////

  // Decoder always presents the B immediate on imm_sb
  assign bch_target_o = pc_i + ctrl_i.imm_sb;

  //////////////////////////////////////////////////
  // Jump target
  //////////////////////////////////////////////////

  // JAL is pc relative, JALR uses the forwarded rs1
  assign jmp_base = ctrl_i.alu_jmpr ? rs1_i : pc_i;

  // imm_b holds the J immediate for JAL and the I immediate for JALR
  assign jmp_sum = jmp_base + ctrl_i.imm_b;

  // JALR clears bit 0 of the sum
  assign jmp_target_o = {jmp_sum[XLEN-1:1], jmp_sum[0] & ~ctrl_i.alu_jmpr};

  // Sequential PC, used by EX for not-taken branches
  assign pc_next_o = pc_i + XLEN'(4);

endmodule

/* verilog/id_ex_register.sv */
// Operand A, pc_next and rf_waddr keep their old value when unused, so compare them only when used
`timescale 1ns/1ps

module id_ex_register import id_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  if_id_t    if_id_i,
  input  dec_ctrl_t ctrl_i,
  input  word_t     rs1_i,
  input  word_t     rs2_i,
  input  word_t     bch_target_i,
  input  word_t     pc_next_i,
  input  logic      halt_id_i,
  input  logic      kill_id_i,
  input  logic      ex_ready_i,
  output logic      id_ready_o,
  output id_ex_t    id_ex_o
);

  word_t operand_a;
  word_t operand_b;
  word_t operand_c;
  logic  id_valid;
  logic  transfer;

  //////////////////////////////////////////////////
  // Operand muxes
  //////////////////////////////////////////////////

  always_comb begin
    case (ctrl_i.op_a_sel)
      OP_A_REG: operand_a = rs1_i;
      OP_A_PC:  operand_a = if_id_i.pc;
      default:  operand_a = '0;
    endcase
  end

  always_comb begin
    case (ctrl_i.op_b_sel)
      OP_B_IMM:    operand_b = ctrl_i.imm_b;
      OP_B_PCINCR: operand_b = XLEN'(4);
      default:     operand_b = rs2_i;
    endcase
  end

  // Store data or branch target
  assign operand_c = (ctrl_i.op_c_sel == OP_C_BCH) ? bch_target_i : rs2_i;

  //////////////////////////////////////////////////
  // Stage handshake
  //////////////////////////////////////////////////

  // A kill drains ID even when EX stalls
  assign id_ready_o = kill_id_i || (ex_ready_i && !halt_id_i);
  assign id_valid   = if_id_i.instr_valid && !halt_id_i && !kill_id_i;
  assign transfer   = id_valid && ex_ready_i;

  //////////////////////////////////////////////////
  // Pipeline register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_o <= '0;
    end else if (transfer) begin
      id_ex_o.valid <= 1'b1;
      id_ex_o.pc    <= if_id_i.pc;
      // LUI leaves operand A untouched
      if (ctrl_i.op_a_sel != OP_A_ZERO) begin
        id_ex_o.operand_a <= operand_a;
      end
      id_ex_o.operand_b <= operand_b;
      id_ex_o.operand_c <= operand_c;
      id_ex_o.alu_en    <= ctrl_i.alu_en;
      id_ex_o.alu_bch   <= ctrl_i.alu_bch;
      id_ex_o.alu_jmp   <= ctrl_i.alu_jmp;
      id_ex_o.alu_op    <= ctrl_i.alu_op;
      id_ex_o.lsu_en    <= ctrl_i.lsu_en;
      id_ex_o.lsu_we    <= ctrl_i.lsu_we;
      id_ex_o.lsu_size  <= ctrl_i.lsu_size;
      id_ex_o.lsu_sext  <= ctrl_i.lsu_sext;
      id_ex_o.rf_we     <= ctrl_i.rf_we;
      id_ex_o.illegal   <= ctrl_i.illegal;
      // Destination only matters with a write-back
      if (ctrl_i.rf_we) begin
        id_ex_o.rf_waddr <= if_id_i.instr[RD_LSB +: REG_ADDR_W];
      end
      // Fall-through PC only needed by branches
      if (ctrl_i.alu_en && ctrl_i.alu_bch) begin
        id_ex_o.pc_next <= pc_next_i;
      end
    end else if (ex_ready_i) begin
      // Bubble into EX
      id_ex_o.valid <= 1'b0;
    end
  end

  // EX back-pressure freezes the whole register
  assert property (@(posedge clk) disable iff (!rst_n) !ex_ready_i |=> $stable(id_ex_o))
    else $error("ID/EX changed while EX stalled");

endmodule

/* verilog/id_stage.sv */
// Register file reads are combinational in the same cycle; forwarding compares only EX and WB
`timescale 1ns/1ps

module id_stage import id_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  if_id_t    if_id_i,
  input  wr_port_t  ex_wr_i,
  input  wr_port_t  wb_wr_i,
  input  word_t     rf_rdata_i [NUM_READ_PORTS],
  output reg_addr_t rf_raddr_o [NUM_READ_PORTS],
  input  logic      halt_id_i,
  input  logic      kill_id_i,
  input  logic      ex_ready_i,
  output logic      id_ready_o,
  output word_t     jmp_target_o,
  output id_ex_t    id_ex_o
);

  dec_ctrl_t ctrl;
  word_t     operand_fw [NUM_READ_PORTS];
  word_t     bch_target;
  word_t     pc_next;

  // Port 0 reads rs1, port 1 reads rs2
  assign rf_raddr_o[0] = if_id_i.instr[RS1_LSB +: REG_ADDR_W];
  assign rf_raddr_o[1] = if_id_i.instr[RS2_LSB +: REG_ADDR_W];

  id_decoder u_decoder (
    .instr_i (if_id_i.instr),
    .ctrl_o  (ctrl)
  );

  // One forwarding unit per read port
  for (genvar i = 0; i < NUM_READ_PORTS; i++) begin : g_fwd
    id_operand_fwd u_fwd (
      .raddr_i    (rf_raddr_o[i]),
      .rf_rdata_i (rf_rdata_i[i]),
      .ex_wr_i    (ex_wr_i),
      .wb_wr_i    (wb_wr_i),
      .operand_o  (operand_fw[i])
    );
  end

  id_target u_target (
    .pc_i         (if_id_i.pc),
    .ctrl_i       (ctrl),
    .rs1_i        (operand_fw[0]),
    .bch_target_o (bch_target),
    .jmp_target_o (jmp_target_o),
    .pc_next_o    (pc_next)
  );

  id_ex_register u_id_ex (
    .clk          (clk),
    .rst_n        (rst_n),
    .if_id_i      (if_id_i),
    .ctrl_i       (ctrl),
    .rs1_i        (operand_fw[0]),
    .rs2_i        (operand_fw[1]),
    .bch_target_i (bch_target),
    .pc_next_i    (pc_next),
    .halt_id_i    (halt_id_i),
    .kill_id_i    (kill_id_i),
    .ex_ready_i   (ex_ready_i),
    .id_ready_o   (id_ready_o),
    .id_ex_o      (id_ex_o)
  );

endmodule

/* verif/id_ref_model.svh */
// Model of the ID stage for the testbench; operand A loaded by an illegal instruction is unpredicted
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

//////////////////////////////////////////////////
// Decode
//////////////////////////////////////////////////

// OP and OP-IMM arithmetic, alt is instruction bit 30
function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt, input logic is_reg);
  alu_op_e op;
  case (f3)
    3'd0:    op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
    3'd1:    op = ALU_SLL;
    3'd2:    op = ALU_SLT;
    3'd3:    op = ALU_SLTU;
    3'd4:    op = ALU_XOR;
    3'd5:    op = alt ? ALU_SRA : ALU_SRL;
    3'd6:    op = ALU_OR;
    default: op = ALU_AND;
  endcase
  return op;
endfunction

function automatic dec_ctrl_t decode_instr(input word_t instr);
  dec_ctrl_t  d;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       ok;
  f3 = instr[14:12];
  f7 = instr[31:25];
  ok = 1'b1;
  d  = '0;
  d.alu_op   = ALU_ADD;
  d.op_a_sel = OP_A_REG;
  d.op_b_sel = OP_B_REG;
  d.op_c_sel = OP_C_REGB;
  // I immediate unless the format says otherwise
  d.imm_b  = {{20{instr[31]}}, instr[31:20]};
  d.imm_sb = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  case (instr[6:0])
    OPC_OP: begin
      d.alu_en = 1'b1;
      d.rf_we  = 1'b1;
      d.alu_op = arith_op(f3, instr[30], 1'b1);
      ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
    end
    OPC_OPIMM: begin
      d.alu_en   = 1'b1;
      d.rf_we    = 1'b1;
      d.op_b_sel = OP_B_IMM;
      d.alu_op   = arith_op(f3, instr[30], 1'b0);
      // Shift amounts leave funct7 as the only legal upper bits
      if (f3 == 3'd1) begin
        ok = (f7 == 7'h00);
      end
      if (f3 == 3'd5) begin
        ok = (f7 == 7'h00) || (f7 == 7'h20);
      end
    end
    OPC_LUI, OPC_AUIPC: begin
      d.alu_en   = 1'b1;
      d.rf_we    = 1'b1;
      d.op_b_sel = OP_B_IMM;
      d.imm_b    = {instr[31:12], 12'b0};
      if (instr[6:0] == OPC_LUI) begin
        d.op_a_sel = OP_A_ZERO;
      end else begin
        d.op_a_sel = OP_A_PC;
      end
    end
    OPC_JAL, OPC_JALR: begin
      // Link value pc + 4 goes through the ALU
      d.alu_en   = 1'b1;
      d.alu_jmp  = 1'b1;
      d.rf_we    = 1'b1;
      d.op_a_sel = OP_A_PC;
      d.op_b_sel = OP_B_PCINCR;
      if (instr[6:0] == OPC_JAL) begin
        d.imm_b = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end else begin
        d.alu_jmpr = 1'b1;
        ok = (f3 == 3'd0);
      end
    end
    OPC_BRANCH: begin
      d.alu_en   = 1'b1;
      d.alu_bch  = 1'b1;
      d.op_c_sel = OP_C_BCH;
      case (f3)
        3'd0:    d.alu_op = ALU_EQ;
        3'd1:    d.alu_op = ALU_NE;
        3'd4:    d.alu_op = ALU_LT;
        3'd5:    d.alu_op = ALU_GE;
        3'd6:    d.alu_op = ALU_LTU;
        3'd7:    d.alu_op = ALU_GEU;
        default: ok = 1'b0;
      endcase
    end
    OPC_LOAD: begin
      d.lsu_en   = 1'b1;
      d.rf_we    = 1'b1;
      d.lsu_size = f3[1:0];
      d.lsu_sext = !f3[2];
      d.op_b_sel = OP_B_IMM;
      ok = (f3 != 3'd3) && (f3 != 3'd6) && (f3 != 3'd7);
    end
    OPC_STORE: begin
      d.lsu_en   = 1'b1;
      d.lsu_we   = 1'b1;
      d.lsu_size = f3[1:0];
      d.op_b_sel = OP_B_IMM;
      d.imm_b    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      ok = (f3 <= 3'd2);
    end
    default: ok = 1'b0;
  endcase
  // Illegal encodings start nothing
  if (!ok) begin
    d.alu_en   = 1'b0;
    d.alu_bch  = 1'b0;
    d.alu_jmp  = 1'b0;
    d.alu_jmpr = 1'b0;
    d.lsu_en   = 1'b0;
    d.lsu_we   = 1'b0;
    d.lsu_sext = 1'b0;
    d.rf_we    = 1'b0;
  end
  d.illegal = !ok;
  return d;
endfunction

//////////////////////////////////////////////////
// Forwarding, targets and the ID/EX register
//////////////////////////////////////////////////

// EX before WB before the register file, x0 never forwarded
function automatic word_t forward_operand(input reg_addr_t addr, input word_t rf,
                                          input wr_port_t ex, input wr_port_t wb);
  if (addr == '0) begin
    return rf;
  end
  if (ex.we && ex.waddr == addr) begin
    return ex.wdata;
  end
  if (wb.we && wb.waddr == addr) begin
    return wb.wdata;
  end
  return rf;
endfunction

function automatic word_t jump_target(input dec_ctrl_t d, input word_t pc, input word_t rs1);
  word_t sum;
  if (d.alu_jmpr) begin
    sum = rs1 + d.imm_b;
    return {sum[31:1], 1'b0};
  end
  return pc + d.imm_b;
endfunction

function automatic logic transfer_expected(input if_id_t fetch, input logic halt,
                                           input logic kill, input logic ready);
  return fetch.instr_valid && !halt && !kill && ready;
endfunction

// Register contents after the next edge
function automatic id_ex_t next_id_ex(input id_ex_t cur, input if_id_t fetch,
                                      input dec_ctrl_t d, input word_t rs1, input word_t rs2,
                                      input logic halt, input logic kill, input logic ready);
  id_ex_t n;
  n = cur;
  if (transfer_expected(fetch, halt, kill, ready)) begin
    n.valid = 1'b1;
    n.pc    = fetch.pc;
    if (d.op_a_sel == OP_A_PC) begin
      n.operand_a = fetch.pc;
    end else if (d.op_a_sel == OP_A_REG) begin
      n.operand_a = rs1;
    end
    case (d.op_b_sel)
      OP_B_IMM:    n.operand_b = d.imm_b;
      OP_B_PCINCR: n.operand_b = 32'd4;
      default:     n.operand_b = rs2;
    endcase
    n.operand_c = (d.op_c_sel == OP_C_BCH) ? fetch.pc + d.imm_sb : rs2;
    n.alu_en    = d.alu_en;
    n.alu_bch   = d.alu_bch;
    n.alu_jmp   = d.alu_jmp;
    n.alu_op    = d.alu_op;
    n.lsu_en    = d.lsu_en;
    n.lsu_we    = d.lsu_we;
    n.lsu_size  = d.lsu_size;
    n.lsu_sext  = d.lsu_sext;
    n.rf_we     = d.rf_we;
    n.illegal   = d.illegal;
    if (d.rf_we) begin
      n.rf_waddr = fetch.instr[RD_LSB +: REG_ADDR_W];
    end
    if (d.alu_bch) begin
      n.pc_next = fetch.pc + 32'd4;
    end
  end else if (ready) begin
    n.valid = 1'b0;
  end
  return n;
endfunction

`endif

/* verif/tb_id_stage.sv */
// Random self-checking testbench; register file data and EX/WB write ports are random stimulus
`timescale 1ns/1ps

module tb_id_stage import id_pkg::*; ();

  localparam int unsigned NUM_CYCLES  = 3000;
  localparam int unsigned READY_LIMIT = 20;

  logic      clk;
  logic      rst_n;
  if_id_t    if_id;
  wr_port_t  ex_wr;
  wr_port_t  wb_wr;
  word_t     rf_rdata [NUM_READ_PORTS];
  reg_addr_t rf_raddr [NUM_READ_PORTS];
  logic      halt_id;
  logic      kill_id;
  logic      ex_ready;
  logic      id_ready;
  word_t     jmp_target;
  id_ex_t    id_ex;

  logic [31:0] lfsr;
  id_ex_t      exp_id_ex;
  logic        opa_known;
  int unsigned mismatch_cnt;
  int unsigned timeout_cnt;

  `include "id_ref_model.svh"

  id_stage UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .if_id_i      (if_id),
    .ex_wr_i      (ex_wr),
    .wb_wr_i      (wb_wr),
    .rf_rdata_i   (rf_rdata),
    .rf_raddr_o   (rf_raddr),
    .halt_id_i    (halt_id),
    .kill_id_i    (kill_id),
    .ex_ready_i   (ex_ready),
    .id_ready_o   (id_ready),
    .jmp_target_o (jmp_target),
    .id_ex_o      (id_ex)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Random source
  //////////////////////////////////////////////////

  // Galois form, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    int unsigned i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return r;
  endfunction

  // Half the time the write address hits one of the sources
  function automatic wr_port_t random_wr_port(input word_t instr);
    wr_port_t   p;
    logic [1:0] how;
    how     = 2'(rand_bits(2));
    p.we    = (rand_bits(1) == 32'd1);
    p.waddr = reg_addr_t'(rand_bits(5));
    if (how == 2'd0) begin
      p.waddr = instr[RS1_LSB +: REG_ADDR_W];
    end else if (how == 2'd1) begin
      p.waddr = instr[RS2_LSB +: REG_ADDR_W];
    end
    p.wdata = rand_bits(32);
    return p;
  endfunction

  task automatic drive_random_inputs();
    logic [3:0] pick;
    word_t      instr;
    pick  = 4'(rand_bits(4));
    instr = rand_bits(25) << 7;
    // Mostly legal major opcodes
    case (pick)
      4'd0, 4'd9:  instr[6:0] = OPC_OP;
      4'd1, 4'd10: instr[6:0] = OPC_OPIMM;
      4'd2:        instr[6:0] = OPC_LUI;
      4'd3:        instr[6:0] = OPC_AUIPC;
      4'd4:        instr[6:0] = OPC_JAL;
      4'd5, 4'd11: instr[6:0] = OPC_JALR;
      4'd6, 4'd12: instr[6:0] = OPC_BRANCH;
      4'd7, 4'd13: instr[6:0] = OPC_LOAD;
      4'd8:        instr[6:0] = OPC_STORE;
      default:     instr[6:0] = 7'(rand_bits(7));
    endcase
    if ((instr[6:0] == OPC_OP || instr[6:0] == OPC_OPIMM) && rand_bits(2) != 32'd0) begin
      instr[31:25] = {1'b0, rand_bits(1) == 32'd1, 5'b00000};
    end
    // Some x0 reads
    if (rand_bits(3) == 32'd0) begin
      instr[RS1_LSB +: REG_ADDR_W] = '0;
    end
    if_id.instr_valid = (rand_bits(3) != 32'd0);
    if_id.pc          = rand_bits(30) << 2;
    if_id.instr       = instr;
    rf_rdata[0] = rand_bits(32);
    rf_rdata[1] = rand_bits(32);
    ex_wr       = random_wr_port(instr);
    wb_wr       = random_wr_port(instr);
    halt_id     = (rand_bits(3) == 32'd0);
    kill_id     = (rand_bits(3) == 32'd0);
    ex_ready    = (rand_bits(2) != 32'd0);
  endtask

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_bit(input logic act, input logic expected, input string what);
    if (act !== expected) begin
      mismatch_cnt++;
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, act, expected);
    end
  endtask

  task automatic check_addr(input reg_addr_t act, input reg_addr_t expected, input string what);
    if (act !== expected) begin
      mismatch_cnt++;
      $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, act, expected);
    end
  endtask

  task automatic check_word(input word_t act, input word_t expected, input string what);
    if (act !== expected) begin
      mismatch_cnt++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, act, expected);
    end
  endtask

  task automatic check_id_ex(input id_ex_t act, input id_ex_t expected, input logic opa_valid);
    id_ex_t a;
    id_ex_t e;
    a = act;
    e = expected;
    if (!opa_valid) begin
      a.operand_a = '0;
      e.operand_a = '0;
    end
    // An illegal encoding only fixes its enables
    if (expected.illegal) begin
      a.alu_op    = ALU_ADD;
      e.alu_op    = ALU_ADD;
      a.lsu_size  = '0;
      e.lsu_size  = '0;
      a.operand_b = '0;
      e.operand_b = '0;
      a.operand_c = '0;
      e.operand_c = '0;
    end
    if (a !== e) begin
      mismatch_cnt++;
      $display("CHECK FAILED at %0t ns: id_ex_o is %h, expected %h", $time, act, expected);
    end
  endtask

  // Same-cycle outputs, then the model step for the coming edge
  task automatic check_and_predict();
    dec_ctrl_t d;
    word_t     rs1;
    word_t     rs2;
    d   = decode_instr(if_id.instr);
    rs1 = forward_operand(if_id.instr[RS1_LSB +: REG_ADDR_W], rf_rdata[0], ex_wr, wb_wr);
    rs2 = forward_operand(if_id.instr[RS2_LSB +: REG_ADDR_W], rf_rdata[1], ex_wr, wb_wr);
    check_addr(rf_raddr[0], if_id.instr[RS1_LSB +: REG_ADDR_W], "rs1 read address");
    check_addr(rf_raddr[1], if_id.instr[RS2_LSB +: REG_ADDR_W], "rs2 read address");
    check_bit(id_ready, kill_id || (ex_ready && !halt_id), "id_ready_o");
    if (d.alu_jmp) begin
      check_word(jmp_target, jump_target(d, if_id.pc, rs1), "jmp_target_o");
    end
    if (transfer_expected(if_id, halt_id, kill_id, ex_ready)) begin
      if (d.illegal) begin
        opa_known = 1'b0;
      end else if (d.op_a_sel != OP_A_ZERO) begin
        opa_known = 1'b1;
      end
    end
    exp_id_ex = next_id_ex(exp_id_ex, if_id, d, rs1, rs2, halt_id, kill_id, ex_ready);
  endtask

  task automatic wait_for_id_ready(input int unsigned limit);
    int unsigned cycles;
    cycles = 0;
    #1;
    while (!id_ready && cycles < limit) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (!id_ready) begin
      timeout_cnt++;
      $display("Timeout: id_ready_o stayed low with EX ready and no halt");
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    rst_n        = 1'b0;
    if_id        = '0;
    ex_wr        = '0;
    wb_wr        = '0;
    rf_rdata[0]  = '0;
    rf_rdata[1]  = '0;
    halt_id      = 1'b0;
    kill_id      = 1'b0;
    ex_ready     = 1'b0;
    lfsr         = 32'hc3ca_ce27;
    exp_id_ex    = '0;
    opa_known    = 1'b1;
    mismatch_cnt = 0;
    timeout_cnt  = 0;

    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Register must come out of reset empty
    check_id_ex(id_ex, exp_id_ex, opa_known);
    ex_ready = 1'b1;
    wait_for_id_ready(READY_LIMIT);

    repeat (NUM_CYCLES) begin
      @(posedge clk);
      #1;
      check_id_ex(id_ex, exp_id_ex, opa_known);
      drive_random_inputs();
      #1;
      check_and_predict();
    end
    @(posedge clk);
    #1;
    check_id_ex(id_ex, exp_id_ex, opa_known);

    $display("Summary: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
    if (mismatch_cnt == 0 && timeout_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+verif
verilog/id_pkg.sv
verilog/id_decoder.sv
verilog/id_operand_fwd.sv
verilog/id_target.sv
verilog/id_ex_register.sv
verilog/id_stage.sv
verif/tb_id_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_id_stage -f build.f \
  --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "No errors" "$LOG_FILE"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed, see $LOG_FILE"
exit 1
